// ==== cla.f ====
cla_pkg.sv
cla_csr_pkg.sv
cla_event_match.sv
cla_node_table.sv
cla_action_gen.sv
cla_counters.sv
cla_top.sv
cla_assert.sv
cla_tb.sv

// ==== Bender.yml ====
package:
  name: cla

sources:
  - cla_pkg.sv
  - cla_csr_pkg.sv
  - cla_event_match.sv
  - cla_node_table.sv
  - cla_action_gen.sv
  - cla_counters.sv
  - cla_top.sv
  - target: test
    files:
      - cla_assert.sv
      - cla_tb.sv

// ==== cla_tb.sv ====
// Randomized testbench for the logic analyzer top, checked against a cycle-based model.
// Runs six tests, each from reset, and prints one line per test and a closing summary.
`timescale 1ns/10ps

module cla_tb
   import cla_pkg::*;
   import cla_csr_pkg::*;
();

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 10;
   localparam int NUM_TESTS    = 6;
   localparam int TEST_CYCLES  = 500;
   localparam int TOTAL_CYCLES = NUM_TESTS * (RESET_CYCLES + TEST_CYCLES) + 1;
   localparam int CYCLE_LIMIT  = TOTAL_CYCLES + TOTAL_CYCLES / 10;

   logic                                    clock;
   logic                                    rst_n;
   logic [DEBUG_BUS_W-1:0]                  debug_bus;
   cla_ctrl_t                               ctrl;
   cla_node_cfg_t                           node_cfg [CLA_NUMBER_OF_NODES];
   cla_ext_actions_t                        ext_actions;
   logic [CLA_NUMBER_OF_CUSTOM_ACTIONS-1:0] custom_action_bus;
   logic [XTRIGGER_WIDTH-1:0]               self_filter;
   logic                                    clock_halt_global;
   logic                                    clock_halt_local;
   logic [CLA_NODE_ID_W-1:0]                current_node_id;
   logic [COUNTER_W-1:0]                    counter_value [CLA_NUMBER_OF_COUNTERS];

   // Reference model state
   logic [CLA_NUMBER_OF_NODES-1:0]          m_hit;
   logic [CLA_NODE_ID_W-1:0]                m_node;
   logic [CLA_NUMBER_OF_ACTIONS-1:0]        m_actions;
   logic [CLA_NUMBER_OF_CUSTOM_ACTIONS-1:0] m_custom;
   logic                                    m_halt_global;
   logic                                    m_halt_local;
   int unsigned                             m_filter_left [XTRIGGER_WIDTH];
   logic [COUNTER_W-1:0]                    m_count [CLA_NUMBER_OF_COUNTERS];
   logic                                    m_running [CLA_NUMBER_OF_COUNTERS];

   int error_count;
   int cycle_count;
   int passed_tests;
   int failed_tests;

   cla_top i_cla_top (
      .clock             (clock),
      .rst_n             (rst_n),
      .debug_bus         (debug_bus),
      .ctrl              (ctrl),
      .node_cfg          (node_cfg),
      .ext_actions       (ext_actions),
      .custom_action_bus (custom_action_bus),
      .self_filter       (self_filter),
      .clock_halt_global (clock_halt_global),
      .clock_halt_local  (clock_halt_local),
      .current_node_id   (current_node_id),
      .counter_value     (counter_value)
   );

   initial begin
      clock = 1'b0;
      forever #(CLK_PERIOD / 2) clock = ~clock;
   end

   // Watchdog on the total run length
   always @(posedge clock) begin
      cycle_count++;
      if (cycle_count > CYCLE_LIMIT) begin
         $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   task automatic reset_model();
      m_hit         = '0;
      m_node        = '0;
      m_actions     = '0;
      m_custom      = '0;
      m_halt_global = 1'b0;
      m_halt_local  = 1'b0;
      for (int i = 0; i < XTRIGGER_WIDTH; i++) begin
         m_filter_left[i] = 0;
      end
      for (int j = 0; j < CLA_NUMBER_OF_COUNTERS; j++) begin
         m_count[j]   = '0;
         m_running[j] = 1'b0;
      end
   endtask

   // One clock edge of the model; registered state moves on old values
   task automatic step_model();
      int base;
      if (!rst_n) begin
         reset_model();
      end else begin
         for (int i = 0; i < XTRIGGER_WIDTH; i++) begin
            if (m_filter_left[i] != 0) begin
               m_filter_left[i]--;
            end else if (m_actions[ACTION_XTRIGGER0_OUT + i] && ctrl.chain_loop_delay != 0) begin
               m_filter_left[i] = ctrl.chain_loop_delay;
            end
         end
         m_halt_global |= m_actions[ACTION_CLOCK_HALT] & ctrl.clock_halt_global_en;
         m_halt_local  |= m_actions[ACTION_CLOCK_HALT] & ctrl.clock_halt_local_en;
         for (int j = 0; j < CLA_NUMBER_OF_COUNTERS; j++) begin
            base = ACTION_BASE_COUNTER + CLA_ACTIONS_PER_COUNTER * j;
            if (m_actions[base + 1]) begin
               m_count[j]   = '0;
               m_running[j] = 1'b0;
            end else begin
               if (m_actions[base] || m_running[j]) m_count[j]++;
               if (m_actions[base + 3]) m_running[j] = 1'b0;
               else if (m_actions[base + 2]) m_running[j] = 1'b1;
            end
         end
         // Walk the node graph from the hits seen one edge earlier
         m_actions = '0;
         m_custom  = '0;
         if (!ctrl.enable_eap) begin
            m_node = '0;
         end else if (m_hit[m_node]) begin
            m_actions = node_cfg[m_node].actions;
            m_custom  = node_cfg[m_node].custom_actions;
            m_node    = node_cfg[m_node].dest_node;
         end
         for (int n = 0; n < CLA_NUMBER_OF_NODES; n++) begin
            m_hit[n] = (debug_bus & node_cfg[n].match_mask) ==
                       (node_cfg[n].match_value & node_cfg[n].match_mask);
         end
      end
   endtask

   function automatic cla_ext_actions_t expected_ext_actions();
      cla_ext_actions_t e;
      e.debug_interrupt = m_actions[ACTION_DEBUG_INTERRUPT];
      e.toggle_gpio     = m_actions[ACTION_TOGGLE_GPIO];
      e.start_trace     = m_actions[ACTION_START_TRACE];
      e.stop_trace      = m_actions[ACTION_STOP_TRACE];
      e.trace_pulse     = m_actions[ACTION_TRACE_PULSE];
      e.xtrigger_out[0] = m_actions[ACTION_XTRIGGER0_OUT];
      e.xtrigger_out[1] = m_actions[ACTION_XTRIGGER1_OUT];
      return e;
   endfunction

   // Zero delay filters at once, otherwise on the last cycle of the count
   function automatic logic [XTRIGGER_WIDTH-1:0] expected_self_filter();
      logic [XTRIGGER_WIDTH-1:0] result;
      result = '0;
      for (int i = 0; i < XTRIGGER_WIDTH; i++) begin
         if (m_filter_left[i] == 1) result[i] = 1'b1;
         else if (m_filter_left[i] == 0 && m_actions[ACTION_XTRIGGER0_OUT + i] &&
                  ctrl.chain_loop_delay == 0) result[i] = 1'b1;
      end
      return result;
   endfunction

   // Failures of the properties bound into the action generator
   function automatic int bound_assert_failures();
      return i_cla_top.i_cla_action_gen.i_cla_assert.fail_count;
   endfunction

   task automatic compare_signal(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
      assert (actual === expected) else begin
         $display("FAILED at %0t ns: %s expected %0h actual %0h", $time, name, expected, actual);
         error_count++;
      end
   endtask

   task automatic check_outputs();
      compare_signal("current_node_id", m_node, current_node_id);
      compare_signal("ext_actions", expected_ext_actions(), ext_actions);
      compare_signal("custom_action_bus", m_custom, custom_action_bus);
      compare_signal("self_filter", expected_self_filter(), self_filter);
      compare_signal("clock_halt_global", m_halt_global, clock_halt_global);
      compare_signal("clock_halt_local", m_halt_local, clock_halt_local);
      compare_signal("counter_value[0]", m_count[0], counter_value[0]);
      compare_signal("counter_value[1]", m_count[1], counter_value[1]);
   endtask

   // Model steps on the rising edge, outputs are checked at the falling edge
   task automatic run_cycle();
      @(posedge clock);
      step_model();
      @(negedge clock);
      check_outputs();
   endtask

   task automatic randomize_config(input int test_id);
      for (int n = 0; n < CLA_NUMBER_OF_NODES; n++) begin
         node_cfg[n].match_mask     = ($urandom_range(7) == 0) ? '0 : 16'($urandom);
         node_cfg[n].match_value    = 16'($urandom);
         node_cfg[n].dest_node      = 2'($urandom);
         node_cfg[n].actions        = 16'($urandom);
         node_cfg[n].custom_actions = 4'($urandom);
         // Counter test keeps only counter controls and makes clears rare
         if (test_id == 2) begin
            node_cfg[n].actions &= 16'hff00;
            if ($urandom_range(3) != 0) node_cfg[n].actions &= ~16'h2200;
         end
         if (test_id == 3 && $urandom_range(1) == 1) node_cfg[n].actions |= 16'h00c0;
      end
      ctrl.enable_eap           = (test_id != 5);
      ctrl.chain_loop_delay     = ($urandom_range(2) == 0) ? '0 : 7'($urandom_range(1, 12));
      ctrl.clock_halt_global_en = 1'($urandom);
      ctrl.clock_halt_local_en  = 1'($urandom);
   endtask

   // Half of the values hit some node's match value
   function automatic logic [DEBUG_BUS_W-1:0] pick_debug_value();
      int n;
      n = $urandom_range(CLA_NUMBER_OF_NODES - 1);
      if ($urandom_range(1) == 1) return node_cfg[n].match_value;
      return 16'($urandom);
   endfunction

   task automatic run_test(input int test_id, input string name);
      int errors_before;
      int assert_before;
      int test_errors;
      errors_before = error_count;
      assert_before = bound_assert_failures();
      rst_n     = 1'b0;
      debug_bus = '0;
      randomize_config(test_id);
      repeat (RESET_CYCLES) run_cycle();
      rst_n = 1'b1;
      repeat (TEST_CYCLES) begin
         debug_bus = pick_debug_value();
         run_cycle();
      end
      test_errors = (error_count - errors_before) + (bound_assert_failures() - assert_before);
      if (test_errors == 0) begin
         passed_tests++;
         $display("Test %0d %s: passed", test_id, name);
      end else begin
         failed_tests++;
         $display("Test %0d %s: failed with %0d errors", test_id, name, test_errors);
      end
   endtask

   initial begin
      void'($urandom(32'h1b22_de0b));
      rst_n     = 1'b0;
      debug_bus = '0;
      ctrl      = '0;
      for (int n = 0; n < CLA_NUMBER_OF_NODES; n++) begin
         node_cfg[n] = '0;
      end
      reset_model();
      @(posedge clock);
      @(negedge clock);
      run_test(0, "node walking");
      run_test(1, "action decode");
      run_test(2, "counters");
      run_test(3, "self filter");
      run_test(4, "clock halt");
      run_test(5, "enable_eap low");
      $display("Tests passed: %0d, failed: %0d", passed_tests, failed_tests);
      if (failed_tests == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== cla_assert.sv ====
// Concurrent checks on the action generator, attached to it by bind.
`timescale 1ns/10ps

module cla_assert
   import cla_pkg::*;
   import cla_csr_pkg::*;
(
   input logic                     clock,
   input logic                     rst_n,
   input cla_ctrl_t                ctrl,
   input cla_ext_actions_t         ext_actions,
   input logic                     clock_halt_global,
   input logic                     clock_halt_local,
   input logic [CLA_NODE_ID_W-1:0] current_node_id
);

   // Number of property failures so far
   int fail_count;

   // Halt flags only drop through reset
   halt_sticky: assert property (@(posedge clock)
      $past(rst_n) |-> !$fell(clock_halt_global) && !$fell(clock_halt_local))
      else begin
         $error("clock halt flag fell without reset");
         fail_count++;
      end

   // Disabled machine fires nothing
   disabled_quiet: assert property (@(posedge clock)
      !ctrl.enable_eap |=> ext_actions == '0)
      else begin
         $error("ext_actions active after enable_eap was low");
         fail_count++;
      end

   reset_node: assert property (@(posedge clock)
      !rst_n |=> current_node_id == '0)
      else begin
         $error("current_node_id not zero after reset");
         fail_count++;
      end

endmodule

bind cla_action_gen cla_assert i_cla_assert (
   .clock             (clock),
   .rst_n             (rst_n),
   .ctrl              (ctrl),
   .ext_actions       (ext_actions),
   .clock_halt_global (clock_halt_global),
   .clock_halt_local  (clock_halt_local),
   .current_node_id   (current_node_id)
);

// ==== cla_top.sv ====
// Logic analyzer top: match, node table, action generator and counters.
// Configuration comes in on static ports; only wiring lives here.
`timescale 1ns/10ps

module cla_top
   import cla_pkg::*;
   import cla_csr_pkg::*;
(
   input  logic                                    clock,
   input  logic                                    rst_n,
   input  logic [DEBUG_BUS_W-1:0]                  debug_bus,
   input  cla_ctrl_t                               ctrl,
   input  cla_node_cfg_t                           node_cfg [CLA_NUMBER_OF_NODES],
   output cla_ext_actions_t                        ext_actions,
   output logic [CLA_NUMBER_OF_CUSTOM_ACTIONS-1:0] custom_action_bus,
   output logic [XTRIGGER_WIDTH-1:0]               self_filter,
   output logic                                    clock_halt_global,
   output logic                                    clock_halt_local,
   output logic [CLA_NODE_ID_W-1:0]                current_node_id,
   output logic [COUNTER_W-1:0]                    counter_value [CLA_NUMBER_OF_COUNTERS]
);

   logic [CLA_NUMBER_OF_NODES-1:0]          node_hit;
   logic [CLA_NUMBER_OF_ACTIONS-1:0]        next_node_action_bus [CLA_NUMBER_OF_NODES];
   logic [CLA_NUMBER_OF_CUSTOM_ACTIONS-1:0] next_node_custom_action_bus [CLA_NUMBER_OF_NODES];
   logic [CLA_NODE_ID_W-1:0]                next_destination_node_id [CLA_NUMBER_OF_NODES];
   counter_controls_t                       counter_actions [CLA_NUMBER_OF_COUNTERS];

   cla_event_match i_cla_event_match (
      .clock     (clock),
      .rst_n     (rst_n),
      .debug_bus (debug_bus),
      .node_cfg  (node_cfg),
      .node_hit  (node_hit)
   );

   cla_node_table i_cla_node_table (
      .node_hit                    (node_hit),
      .node_cfg                    (node_cfg),
      .next_node_action_bus        (next_node_action_bus),
      .next_node_custom_action_bus (next_node_custom_action_bus),
      .next_destination_node_id    (next_destination_node_id)
   );

   cla_action_gen i_cla_action_gen (
      .clock                       (clock),
      .rst_n                       (rst_n),
      .ctrl                        (ctrl),
      .next_node_action_bus        (next_node_action_bus),
      .next_node_custom_action_bus (next_node_custom_action_bus),
      .next_destination_node_id    (next_destination_node_id),
      .ext_actions                 (ext_actions),
      .custom_action_bus           (custom_action_bus),
      .self_filter                 (self_filter),
      .clock_halt_global           (clock_halt_global),
      .clock_halt_local            (clock_halt_local),
      .counter_actions             (counter_actions),
      .current_node_id             (current_node_id)
   );

   cla_counters i_cla_counters (
      .clock           (clock),
      .rst_n           (rst_n),
      .counter_actions (counter_actions),
      .counter_value   (counter_value)
   );

endmodule

// ==== cla_counters.sv ====
// Two event counters steered by the counter controls of the action bus.
// Clear wins; otherwise a pulse or auto-increment adds at most one per cycle.
`timescale 1ns/10ps

module cla_counters
   import cla_pkg::*;
(
   input  logic                  clock,
   input  logic                  rst_n,
   input  counter_controls_t     counter_actions [CLA_NUMBER_OF_COUNTERS],
   output logic [COUNTER_W-1:0]  counter_value [CLA_NUMBER_OF_COUNTERS]
);

   // Auto-increment state per counter
   logic [CLA_NUMBER_OF_COUNTERS-1:0] running;

   always_ff @(posedge clock) begin
      if (!rst_n) begin
         running <= '0;
         for (int j = 0; j < CLA_NUMBER_OF_COUNTERS; j++) begin
            counter_value[j] <= '0;
         end
      end else begin
         for (int j = 0; j < CLA_NUMBER_OF_COUNTERS; j++) begin
            if (counter_actions[j].clear_ctr) begin
               counter_value[j] <= '0;
               running[j]       <= 1'b0;
            end else begin
               // Stop beats start when both arrive together
               if (counter_actions[j].stop_auto_increment) begin
                  running[j] <= 1'b0;
               end else if (counter_actions[j].auto_increment) begin
                  running[j] <= 1'b1;
               end
               // Pulse and running do not stack
               if (counter_actions[j].increment_pulse || running[j]) begin
                  counter_value[j] <= counter_value[j] + COUNTER_W'(1);
               end
            end
         end
      end
   end

endmodule

// ==== cla_action_gen.sv ====
// Event state machine core: holds the current node, registers its actions and
// decodes them into strobes, counter controls, clock halts and the self filter.
`timescale 1ns/10ps

module cla_action_gen
   import cla_pkg::*;
   import cla_csr_pkg::*;
(
   input  logic                                    clock,
   input  logic                                    rst_n,
   input  cla_ctrl_t                               ctrl,
   input  logic [CLA_NUMBER_OF_ACTIONS-1:0]        next_node_action_bus [CLA_NUMBER_OF_NODES],
   input  logic [CLA_NUMBER_OF_CUSTOM_ACTIONS-1:0] next_node_custom_action_bus
                                                      [CLA_NUMBER_OF_NODES],
   input  logic [CLA_NODE_ID_W-1:0]                next_destination_node_id
                                                      [CLA_NUMBER_OF_NODES],
   output cla_ext_actions_t                        ext_actions,
   output logic [CLA_NUMBER_OF_CUSTOM_ACTIONS-1:0] custom_action_bus,
   output logic [XTRIGGER_WIDTH-1:0]               self_filter,
   output logic                                    clock_halt_global,
   output logic                                    clock_halt_local,
   output counter_controls_t                       counter_actions [CLA_NUMBER_OF_COUNTERS],
   output logic [CLA_NODE_ID_W-1:0]                current_node_id
);

   logic [CLA_NODE_ID_W-1:0]                next_current_node_id;
   logic [CLA_NUMBER_OF_ACTIONS-1:0]        action_bus;
   logic [CLA_NUMBER_OF_ACTIONS-1:0]        next_action_bus;
   logic [CLA_NUMBER_OF_CUSTOM_ACTIONS-1:0] next_custom_action_bus;

   logic [XTRIGGER_WIDTH-1:0][CHAIN_LOOP_DELAY_W-1:0] filter_cnt;
   logic [XTRIGGER_WIDTH-1:0][CHAIN_LOOP_DELAY_W-1:0] next_filter_cnt;

   // Only the current node's entry matters; disabled parks in node 0
   always_comb begin
      next_current_node_id   = '0;
      next_action_bus        = '0;
      next_custom_action_bus = '0;
      if (ctrl.enable_eap) begin
         next_current_node_id   = next_destination_node_id[current_node_id];
         next_action_bus        = next_node_action_bus[current_node_id];
         next_custom_action_bus = next_node_custom_action_bus[current_node_id];
      end
   end

   always_ff @(posedge clock) begin
      if (!rst_n) begin
         current_node_id   <= '0;
         action_bus        <= '0;
         custom_action_bus <= '0;
         filter_cnt        <= '0;
         clock_halt_global <= 1'b0;
         clock_halt_local  <= 1'b0;
      end else begin
         current_node_id   <= next_current_node_id;
         action_bus        <= next_action_bus;
         custom_action_bus <= next_custom_action_bus;
         filter_cnt        <= next_filter_cnt;
         // Sticky until reset
         if (action_bus[ACTION_CLOCK_HALT] && ctrl.clock_halt_global_en) begin
            clock_halt_global <= 1'b1;
         end
         if (action_bus[ACTION_CLOCK_HALT] && ctrl.clock_halt_local_en) begin
            clock_halt_local <= 1'b1;
         end
      end
   end

   // External strobes
   always_comb begin
      ext_actions.debug_interrupt = action_bus[ACTION_DEBUG_INTERRUPT];
      ext_actions.toggle_gpio     = action_bus[ACTION_TOGGLE_GPIO];
      ext_actions.start_trace     = action_bus[ACTION_START_TRACE];
      ext_actions.stop_trace      = action_bus[ACTION_STOP_TRACE];
      ext_actions.trace_pulse     = action_bus[ACTION_TRACE_PULSE];
      ext_actions.xtrigger_out[0] = action_bus[ACTION_XTRIGGER0_OUT];
      ext_actions.xtrigger_out[1] = action_bus[ACTION_XTRIGGER1_OUT];
   end

   // Counter controls, four bits per counter above the base
   always_comb begin
      for (int j = 0; j < CLA_NUMBER_OF_COUNTERS; j++) begin
         counter_actions[j].increment_pulse =
            action_bus[ACTION_BASE_COUNTER + j*CLA_ACTIONS_PER_COUNTER + CTR_OFS_INCREMENT];
         counter_actions[j].clear_ctr =
            action_bus[ACTION_BASE_COUNTER + j*CLA_ACTIONS_PER_COUNTER + CTR_OFS_CLEAR];
         counter_actions[j].auto_increment =
            action_bus[ACTION_BASE_COUNTER + j*CLA_ACTIONS_PER_COUNTER + CTR_OFS_AUTO_INC];
         counter_actions[j].stop_auto_increment =
            action_bus[ACTION_BASE_COUNTER + j*CLA_ACTIONS_PER_COUNTER + CTR_OFS_STOP_AUTO];
      end
   end

   // Self filter masks our own xtrigger when it comes back around the chain.
   // An idle count starts on a trigger; later triggers wait for it to expire.
   always_comb begin
      next_filter_cnt = filter_cnt;
      self_filter     = '0;
      for (int i = 0; i < XTRIGGER_WIDTH; i++) begin
         if (filter_cnt[i] == '0) begin
            if (ext_actions.xtrigger_out[i] && ctrl.chain_loop_delay == '0) begin
               self_filter[i] = 1'b1;
            end else if (ext_actions.xtrigger_out[i]) begin
               next_filter_cnt[i] = CHAIN_LOOP_DELAY_W'(1);
            end
         end else if (filter_cnt[i] >= ctrl.chain_loop_delay) begin
            // Loop delay reached
            next_filter_cnt[i] = '0;
            self_filter[i]     = 1'b1;
         end else begin
            next_filter_cnt[i] = filter_cnt[i] + CHAIN_LOOP_DELAY_W'(1);
         end
      end
   end

endmodule

// ==== cla_node_table.sv ====
// Per-node transition table built from the registered hits.
// Purely combinational; the action generator picks the current node's entry.
`timescale 1ns/10ps

module cla_node_table
   import cla_pkg::*;
   import cla_csr_pkg::*;
(
   input  logic [CLA_NUMBER_OF_NODES-1:0]          node_hit,
   input  cla_node_cfg_t                           node_cfg [CLA_NUMBER_OF_NODES],
   output logic [CLA_NUMBER_OF_ACTIONS-1:0]        next_node_action_bus [CLA_NUMBER_OF_NODES],
   output logic [CLA_NUMBER_OF_CUSTOM_ACTIONS-1:0] next_node_custom_action_bus
                                                      [CLA_NUMBER_OF_NODES],
   output logic [CLA_NODE_ID_W-1:0]                next_destination_node_id
                                                      [CLA_NUMBER_OF_NODES]
);

   always_comb begin
      for (int n = 0; n < CLA_NUMBER_OF_NODES; n++) begin
         if (node_hit[n]) begin
            // Matching node jumps and fires its programmed actions
            next_destination_node_id[n]    = node_cfg[n].dest_node;
            next_node_action_bus[n]        = node_cfg[n].actions;
            next_node_custom_action_bus[n] = node_cfg[n].custom_actions;
         end else begin
            // No match, stay put quietly
            next_destination_node_id[n]    = CLA_NODE_ID_W'(n);
            next_node_action_bus[n]        = '0;
            next_node_custom_action_bus[n] = '0;
         end
      end
   end

endmodule

// ==== cla_event_match.sv ====
// Masked compare of the debug bus against every node's match value.
// Hits are registered so the debug bus only reaches a flop.
`timescale 1ns/10ps

module cla_event_match
   import cla_pkg::*;
   import cla_csr_pkg::*;
(
   input  logic                           clock,
   input  logic                           rst_n,
   input  logic [DEBUG_BUS_W-1:0]         debug_bus,
   input  cla_node_cfg_t                  node_cfg [CLA_NUMBER_OF_NODES],
   output logic [CLA_NUMBER_OF_NODES-1:0] node_hit
);

   logic [CLA_NUMBER_OF_NODES-1:0] hit_now;

   // A node hits when every masked bit agrees, so an empty mask always hits
   always_comb begin
      for (int n = 0; n < CLA_NUMBER_OF_NODES; n++) begin
         hit_now[n] = ((debug_bus ^ node_cfg[n].match_value) & node_cfg[n].match_mask)
                      == '0;
      end
   end

   always_ff @(posedge clock) begin
      if (!rst_n) begin
         node_hit <= '0;
      end else begin
         node_hit <= hit_now;
      end
   end

endmodule

// ==== cla_csr_pkg.sv ====
// Software-visible configuration of the logic analyzer.
// Node and control settings are held static by the driver while a capture runs.
package cla_csr_pkg;
   import cla_pkg::*;

   // Loop delay of the cross-trigger chain, up to 127 cycles
   localparam int CHAIN_LOOP_DELAY_W = 7;

   // One event node of the state machine
   typedef struct packed {
      // Bits of the debug bus that take part in the compare
      logic [DEBUG_BUS_W-1:0]                  match_mask;
      logic [DEBUG_BUS_W-1:0]                  match_value;
      // Node entered when this node matches
      logic [CLA_NODE_ID_W-1:0]                dest_node;
      // Actions fired for one cycle on the transition
      logic [CLA_NUMBER_OF_ACTIONS-1:0]        actions;
      logic [CLA_NUMBER_OF_CUSTOM_ACTIONS-1:0] custom_actions;
   } cla_node_cfg_t;

   // Global analyzer controls
   typedef struct packed {
      // Low parks the machine in node 0 with no actions
      logic                          enable_eap;
      // Cycles from our own xtrigger out until it returns on the chain
      logic [CHAIN_LOOP_DELAY_W-1:0] chain_loop_delay;
      logic                          clock_halt_global_en;
      logic                          clock_halt_local_en;
   } cla_ctrl_t;

endpackage

// ==== cla_pkg.sv ====
// Sizes, action bit positions and action structs of the logic analyzer.
// Imported by every analyzer block and by the configuration package.
package cla_pkg;

   localparam int CLA_NUMBER_OF_NODES          = 4;
   localparam int CLA_NODE_ID_W                = $clog2(CLA_NUMBER_OF_NODES);
   localparam int DEBUG_BUS_W                  = 16;
   localparam int CLA_NUMBER_OF_COUNTERS       = 2;
   localparam int CLA_ACTIONS_PER_COUNTER      = 4;
   localparam int CLA_NUMBER_OF_ACTIONS        = 16;
   localparam int CLA_NUMBER_OF_CUSTOM_ACTIONS = 4;
   localparam int XTRIGGER_WIDTH               = 2;
   localparam int COUNTER_W                    = 16;

   // Offsets of one counter's controls above its base action bit
   localparam int CTR_OFS_INCREMENT = 0;
   localparam int CTR_OFS_CLEAR     = 1;
   localparam int CTR_OFS_AUTO_INC  = 2;
   localparam int CTR_OFS_STOP_AUTO = 3;

   // Bit positions on the action bus
   typedef enum logic [$clog2(CLA_NUMBER_OF_ACTIONS)-1:0] {
      ACTION_CLOCK_HALT      = 4'd0,
      ACTION_DEBUG_INTERRUPT = 4'd1,
      ACTION_TOGGLE_GPIO     = 4'd2,
      ACTION_START_TRACE     = 4'd3,
      ACTION_STOP_TRACE      = 4'd4,
      ACTION_TRACE_PULSE     = 4'd5,
      ACTION_XTRIGGER0_OUT   = 4'd6,
      ACTION_XTRIGGER1_OUT   = 4'd7,
      // Counter j uses bits base + 4*j up to base + 4*j + 3
      ACTION_BASE_COUNTER    = 4'd8
   } cla_action_e;

   // Per-counter controls decoded from the action bus
   typedef struct packed {
      logic increment_pulse;
      logic clear_ctr;
      logic auto_increment;
      logic stop_auto_increment;
   } counter_controls_t;

   // Strobes leaving the analyzer, each one cycle wide
   typedef struct packed {
      logic                      debug_interrupt;
      logic                      toggle_gpio;
      logic                      start_trace;
      logic                      stop_trace;
      logic                      trace_pulse;
      logic [XTRIGGER_WIDTH-1:0] xtrigger_out;
   } cla_ext_actions_t;

endpackage
